// File: hdl/elevator_pkg.sv
package elevator_pkg;

    // Number of served floors with index 0 as the lowest floor
    localparam int num_floors = 11;

    // Floor index from 0 to num_floors - 1
    typedef logic [3:0] floor_t;

    // One request bit per floor with bit 0 at the lowest floor
    typedef logic [num_floors-1:0] floor_mask_t;

    // Travel direction values
    localparam logic dir_up   = 1'b1;
    localparam logic dir_down = 1'b0;

    ////////////////////////////////////////////////////////////
    // Car status as seen from the motion controller
    ////////////////////////////////////////////////////////////

    // floor is the floor the car stands at or last passed
    // moving is high between floors
    // powered follows the power switch
    // emergency follows the emergency button
    typedef struct packed {
        floor_t floor;
        logic   moving;
        logic   powered;
        logic   emergency;
    } car_status_t;

    ////////////////////////////////////////////////////////////
    // Door open and close pair
    ////////////////////////////////////////////////////////////

    // Used for the door buttons and for the door permissions
    typedef struct packed {
        logic open;
        logic close;
    } door_request_t;

endpackage

// File: hdl/request_register.sv
`timescale 1ns/10ps

module request_register (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t buttons,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_mask_t lights
);

    logic                      stopped;
    logic                      accept;
    elevator_pkg::floor_mask_t here;
    elevator_pkg::floor_mask_t set_mask;
    elevator_pkg::floor_mask_t clear_mask;

    // Car powered and standing still
    assign stopped = car.powered && !car.moving;

    // Presses only count with power on and no emergency
    assign accept = car.powered && !car.emergency;

    // One-hot mask of the car's floor
    always_comb begin
        for (int i = 0; i < elevator_pkg::num_floors; i++) begin
            here[i] = (car.floor == elevator_pkg::floor_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////
    // Set and clear masks
    ////////////////////////////////////////////////////////////

    // A press at the floor where the car stands is already served
    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        if (accept) begin
            set_mask = stopped ? (buttons & ~here) : buttons;
        end
        if (stopped) begin
            clear_mask = here;
        end
    end

    // Clear wins over a press on the same bit
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= (lights | set_mask) & ~clear_mask;
        end
    end

endmodule

// File: hdl/car_dispatch.sv
`timescale 1ns/10ps

module car_dispatch (
    input  logic                        clock,
    input  logic                        reset_n,
    input  elevator_pkg::floor_mask_t   hall_lights,
    input  elevator_pkg::floor_mask_t   panel_lights,
    input  elevator_pkg::car_status_t   car,
    input  elevator_pkg::door_request_t door_buttons,
    output elevator_pkg::floor_t        target_floor,
    output logic                        direction,
    output logic                        activate,
    output elevator_pkg::door_request_t door_allowed
);

    elevator_pkg::floor_mask_t pending;
    elevator_pkg::floor_mask_t above;
    elevator_pkg::floor_mask_t below;
    elevator_pkg::floor_t      lowest_above;
    elevator_pkg::floor_t      highest_below;
    elevator_pkg::floor_t      next_target;
    logic                      next_direction;
    logic                      chosen;
    logic                      stopped;
    logic                      run_ok;

    assign stopped = !car.moving;
    assign run_ok  = car.powered && !car.emergency && stopped;

    ////////////////////////////////////////////////////////////
    // Pending requests relative to the car
    ////////////////////////////////////////////////////////////

    // The car's own floor drops out while stopped, its light clears next edge
    always_comb begin
        pending = hall_lights | panel_lights;
        for (int i = 0; i < elevator_pkg::num_floors; i++) begin
            if (stopped && car.floor == elevator_pkg::floor_t'(i)) begin
                pending[i] = 1'b0;
            end
            above[i] = pending[i] && (elevator_pkg::floor_t'(i) > car.floor);
            below[i] = pending[i] && (elevator_pkg::floor_t'(i) < car.floor);
        end
    end

    // Nearest request above, scanned top down so the lowest wins
    always_comb begin
        lowest_above = '0;
        for (int i = elevator_pkg::num_floors - 1; i >= 0; i--) begin
            if (above[i]) begin
                lowest_above = elevator_pkg::floor_t'(i);
            end
        end
    end

    // Nearest request below, scanned bottom up so the highest wins
    always_comb begin
        highest_below = '0;
        for (int i = 0; i < elevator_pkg::num_floors; i++) begin
            if (below[i]) begin
                highest_below = elevator_pkg::floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Scan rule
    ////////////////////////////////////////////////////////////

    // Keep going while requests lie ahead, reverse otherwise
    always_comb begin
        next_target    = target_floor;
        next_direction = direction;
        chosen         = 1'b0;
        if (stopped) begin
            if (direction == elevator_pkg::dir_up) begin
                if (|above) begin
                    next_target = lowest_above;
                    chosen      = 1'b1;
                end else if (|below) begin
                    next_target    = highest_below;
                    next_direction = elevator_pkg::dir_down;
                    chosen         = 1'b1;
                end
            end else begin
                if (|below) begin
                    next_target = highest_below;
                    chosen      = 1'b1;
                end else if (|above) begin
                    next_target    = lowest_above;
                    next_direction = elevator_pkg::dir_up;
                    chosen         = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
            direction    <= elevator_pkg::dir_up;
            activate     <= 1'b0;
            door_allowed <= '0;
        end else begin
            target_floor <= next_target;
            direction    <= next_direction;
            activate     <= run_ok && chosen;
            // Doors only move with power on and the car standing
            door_allowed <= (car.powered && stopped) ? door_buttons : '0;
        end
    end

endmodule

// File: hdl/floor_logic_top.sv
`timescale 1ns/10ps

module floor_logic_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  elevator_pkg::floor_mask_t   hall_buttons,
    input  elevator_pkg::floor_mask_t   panel_buttons,
    input  elevator_pkg::door_request_t door_buttons,
    input  elevator_pkg::car_status_t   car,
    output elevator_pkg::floor_mask_t   hall_lights,
    output elevator_pkg::floor_mask_t   panel_lights,
    output elevator_pkg::floor_t        target_floor,
    output logic                        direction,
    output logic                        activate,
    output elevator_pkg::door_request_t door_allowed
);

    ////////////////////////////////////////////////////////////
    // Request latches
    ////////////////////////////////////////////////////////////

    // Hall call buttons on every landing
    request_register hall_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (hall_buttons),
        .car     (car),
        .lights  (hall_lights)
    );

    // Destination buttons inside the car
    request_register panel_requests (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (panel_buttons),
        .car     (car),
        .lights  (panel_lights)
    );

    ////////////////////////////////////////////////////////////
    // Target selection and door permissions
    ////////////////////////////////////////////////////////////

    car_dispatch dispatch (
        .clock        (clock),
        .reset_n      (reset_n),
        .hall_lights  (hall_lights),
        .panel_lights (panel_lights),
        .car          (car),
        .door_buttons (door_buttons),
        .target_floor (target_floor),
        .direction    (direction),
        .activate     (activate),
        .door_allowed (door_allowed)
    );

endmodule

// File: testbench/floor_logic_sva.sv
`timescale 1ns/10ps

module floor_logic_sva (
    input logic                        clock,
    input logic                        reset_n,
    input elevator_pkg::car_status_t   car,
    input elevator_pkg::floor_t        target_floor,
    input logic                        activate,
    input elevator_pkg::door_request_t door_allowed
);

    ////////////////////////////////////////////////////////////
    // Dispatch properties
    ////////////////////////////////////////////////////////////

    // Target never equals the floor the car stood at when it was chosen
    activate_away: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate |-> (target_floor != $past(car.floor))
    ) else $error("activate raised with the target at the car's own floor");

    // Emergency or power loss stops the car request at the next edge
    activate_inhibit: assert property (
        @(posedge clock) disable iff (!reset_n)
        (car.emergency || !car.powered) |=> !activate
    ) else $error("activate stayed high after emergency or power loss");

    // Doors only with power on and the car standing
    doors_when_stopped: assert property (
        @(posedge clock) disable iff (!reset_n)
        (door_allowed.open || door_allowed.close) |-> $past(car.powered && !car.moving)
    ) else $error("door permission given while moving or unpowered");

endmodule

bind car_dispatch floor_logic_sva dispatch_checks (
    .clock        (clock),
    .reset_n      (reset_n),
    .car          (car),
    .target_floor (target_floor),
    .activate     (activate),
    .door_allowed (door_allowed)
);

// File: testbench/floor_logic_tb.sv
`timescale 1ns/10ps

module floor_logic_tb;

    ////////////////////////////////////////////////////////////
    // Stimulus and expected values for one table entry
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        elevator_pkg::car_status_t   car;
        elevator_pkg::floor_mask_t   hall;
        elevator_pkg::floor_mask_t   panel;
        elevator_pkg::door_request_t doors;
        elevator_pkg::floor_mask_t   exp_hall;
        elevator_pkg::floor_mask_t   exp_panel;
        elevator_pkg::floor_t        exp_target;
        logic                        exp_dir;
        logic                        exp_activate;
        elevator_pkg::door_request_t exp_doors;
    } step_t;

    logic                        clock;
    logic                        reset_n;
    elevator_pkg::floor_mask_t   hall_buttons;
    elevator_pkg::floor_mask_t   panel_buttons;
    elevator_pkg::door_request_t door_buttons;
    elevator_pkg::car_status_t   car;
    elevator_pkg::floor_mask_t   hall_lights;
    elevator_pkg::floor_mask_t   panel_lights;
    elevator_pkg::floor_t        target_floor;
    logic                        direction;
    logic                        activate;
    elevator_pkg::door_request_t door_allowed;

    step_t steps [11];
    int    errors;
    int    cycles;

    floor_logic_top UUT (
        .clock         (clock),
        .reset_n       (reset_n),
        .hall_buttons  (hall_buttons),
        .panel_buttons (panel_buttons),
        .door_buttons  (door_buttons),
        .car           (car),
        .hall_lights   (hall_lights),
        .panel_lights  (panel_lights),
        .target_floor  (target_floor),
        .direction     (direction),
        .activate      (activate),
        .door_allowed  (door_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Run limit from reset length, entry count and a margin
    always @(posedge clock) begin
        cycles++;
        if (cycles >= 8 + 4 * $size(steps) + 20) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic elevator_pkg::car_status_t make_car(input int floor, input logic moving,
                                                            input logic powered,
                                                            input logic emergency);
        elevator_pkg::car_status_t c;
        c.floor     = elevator_pkg::floor_t'(floor);
        c.moving    = moving;
        c.powered   = powered;
        c.emergency = emergency;
        return c;
    endfunction

    function automatic step_t make_step(
        input elevator_pkg::car_status_t c,
        input logic [10:0] hall, input logic [10:0] panel, input logic [1:0] doors,
        input logic [10:0] exp_hall, input logic [10:0] exp_panel, input int exp_target,
        input logic exp_dir, input logic exp_activate, input logic [1:0] exp_doors
    );
        step_t s;
        s.car          = c;
        s.hall         = hall;
        s.panel        = panel;
        s.doors        = doors;
        s.exp_hall     = exp_hall;
        s.exp_panel    = exp_panel;
        s.exp_target   = elevator_pkg::floor_t'(exp_target);
        s.exp_dir      = exp_dir;
        s.exp_activate = exp_activate;
        s.exp_doors    = exp_doors;
        return s;
    endfunction

    // Door pairs are written as {open, close}
    // Masks have bit 0 at the lowest floor
    task automatic fill_table;
        // Stopped at 4 with hall 7 and panel 2 pressed so scan up picks 7
        steps[0] = make_step(make_car(4, 0, 1, 0), 11'h080, 11'h004, 2'b00,
                             11'h080, 11'h004, 7, elevator_pkg::dir_up, 1'b1, 2'b00);
        // Presses at the car's own floor are ignored
        steps[1] = make_step(make_car(4, 0, 1, 0), 11'h010, 11'h010, 2'b00,
                             11'h080, 11'h004, 7, elevator_pkg::dir_up, 1'b1, 2'b00);
        // Moving car holds its target and refuses door open
        steps[2] = make_step(make_car(5, 1, 1, 0), 11'h000, 11'h000, 2'b10,
                             11'h080, 11'h004, 7, elevator_pkg::dir_up, 1'b0, 2'b00);
        // Stopped at 7 the hall light clears and the scan reverses to 2
        steps[3] = make_step(make_car(7, 0, 1, 0), 11'h000, 11'h000, 2'b10,
                             11'h000, 11'h004, 2, elevator_pkg::dir_down, 1'b1, 2'b10);
        // Hall 2 pressed on the way down
        steps[4] = make_step(make_car(3, 1, 1, 0), 11'h004, 11'h000, 2'b01,
                             11'h004, 11'h004, 2, elevator_pkg::dir_down, 1'b0, 2'b00);
        // Arrival at 2 clears both lights and leaves nothing pending
        steps[5] = make_step(make_car(2, 0, 1, 0), 11'h000, 11'h000, 2'b01,
                             11'h000, 11'h000, 2, elevator_pkg::dir_down, 1'b0, 2'b01);
        // Emergency blocks presses
        steps[6] = make_step(make_car(2, 0, 1, 1), 11'h200, 11'h001, 2'b00,
                             11'h000, 11'h000, 2, elevator_pkg::dir_down, 1'b0, 2'b00);
        // Power off blocks presses and doors
        steps[7] = make_step(make_car(2, 0, 0, 0), 11'h200, 11'h001, 2'b10,
                             11'h000, 11'h000, 2, elevator_pkg::dir_down, 1'b0, 2'b00);
        // Going down with only floor 9 pending reverses to up
        steps[8] = make_step(make_car(2, 0, 1, 0), 11'h200, 11'h000, 2'b00,
                             11'h200, 11'h000, 9, elevator_pkg::dir_up, 1'b1, 2'b00);
        // Emergency drops activate while the light holds
        steps[9] = make_step(make_car(2, 0, 1, 1), 11'h000, 11'h000, 2'b00,
                             11'h200, 11'h000, 9, elevator_pkg::dir_up, 1'b0, 2'b00);
        // Power loss drops activate while the light holds
        steps[10] = make_step(make_car(2, 0, 0, 0), 11'h000, 11'h000, 2'b00,
                              11'h200, 11'h000, 9, elevator_pkg::dir_up, 1'b0, 2'b00);
    endtask

    task automatic check_value(input string field, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, field, got,
                     expected);
        end
    endtask

    task automatic check_outputs(input string tag, input step_t s);
        check_value({tag, " hall_lights"}, 16'(hall_lights), 16'(s.exp_hall));
        check_value({tag, " panel_lights"}, 16'(panel_lights), 16'(s.exp_panel));
        check_value({tag, " target_floor"}, 16'(target_floor), 16'(s.exp_target));
        check_value({tag, " direction"}, 16'(direction), 16'(s.exp_dir));
        check_value({tag, " activate"}, 16'(activate), 16'(s.exp_activate));
        check_value({tag, " door_allowed"}, 16'(door_allowed), 16'(s.exp_doors));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        step_t reset_values;
        errors        = 0;
        cycles        = 0;
        reset_n       = 1'b0;
        hall_buttons  = '0;
        panel_buttons = '0;
        door_buttons  = '0;
        car           = make_car(0, 0, 1, 0);
        fill_table();

        // Expected state right out of reset
        reset_values = make_step(car, 11'h000, 11'h000, 2'b00,
                                 11'h000, 11'h000, 0, elevator_pkg::dir_up, 1'b0, 2'b00);
        repeat (8) @(posedge clock);
        #1;
        check_outputs("reset", reset_values);
        reset_n = 1'b1;

        for (int i = 0; i < $size(steps); i++) begin
            @(posedge clock);
            #1;
            car           = steps[i].car;
            hall_buttons  = steps[i].hall;
            panel_buttons = steps[i].panel;
            door_buttons  = steps[i].doors;
            repeat (3) @(posedge clock);
            #1;
            check_outputs($sformatf("step %0d", i), steps[i]);
            hall_buttons  = '0;
            panel_buttons = '0;
            door_buttons  = '0;
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/elevator_pkg.sv
hdl/request_register.sv
hdl/car_dispatch.sv
hdl/floor_logic_top.sv
testbench/floor_logic_sva.sv
testbench/floor_logic_tb.sv

// File: Bender.yml
package:
  name: floor_logic

sources:
  # RTL in compile order
  - hdl/elevator_pkg.sv
  - hdl/request_register.sv
  - hdl/car_dispatch.sv
  - hdl/floor_logic_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/floor_logic_sva.sv
      - testbench/floor_logic_tb.sv
